//--- common/ccPkg.sv
package ccPkg;

    localparam int MaxMsgLen = 7;              // longest message in bits
    localparam int RxWidth   = 2 * MaxMsgLen;  // two code bits per message bit

    typedef logic [1:0] stateT;    // [1] newest input, [0] the one before
    typedef logic [3:0] metricT;   // real distances stay at or below 14
    typedef logic [1:0] symbolT;   // first code bit in [1]
    typedef logic [1:0] lenCodeT;  // 0..3 select 3, 4, 5, 7 bits

    // one decode job as it arrives
    typedef struct packed {
        logic [RxWidth-1:0] rxWord;   // symbol 0 at the top of the low 2L bits
        lenCodeT            lenCode;
    } decodeReqT;

    // decoded block handed back
    typedef struct packed {
        logic [MaxMsgLen-1:0] message;  // first bit at L-1, zero above
        metricT               metric;   // distance of the surviving path
    } decodeResT;

    function automatic logic [2:0] msgLength(lenCodeT code);
        case (code)
            2'd0:    return 3'd3;
            2'd1:    return 3'd4;
            2'd2:    return 3'd5;
            default: return 3'd7;  // code 3, six is skipped on purpose
        endcase
    endfunction

    // (7,5) encoder output for one trellis branch
    function automatic symbolT expectedSymbol(stateT state, logic inBit);
        logic g7;
        logic g5;
        g7 = inBit ^ state[1] ^ state[0];  // taps 111
        g5 = inBit ^ state[0];             // taps 101
        return {g7, g5};
    endfunction

endpackage

//--- hw/viterbi/acsUnit.sv
module acsUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,       // load starting metrics
    input  logic           stepEn,      // one trellis step per cycle
    input  logic           finish,      // latch the winning end state
    input  ccPkg::symbolT  symbol,
    output logic [3:0]     decisions,   // chosen predecessor low bit per state
    output ccPkg::stateT   bestState,
    output ccPkg::metricT  bestMetric
);
    import ccPkg::*;

    metricT     pathMetric [4];
    metricT     nextMetric [4];
    logic [4:0] cand0 [4];     // path through predecessor {n[0], 0}
    logic [4:0] cand1 [4];     // path through predecessor {n[0], 1}
    logic [4:0] chosen [4];
    stateT      minState;

    function automatic logic [1:0] branchDist(symbolT rx, symbolT refSym);
        symbolT diff;
        diff = rx ^ refSym;
        return {1'b0, diff[1]} + {1'b0, diff[0]};
    endfunction

    // add-compare-select, state n = {input, older}, so predecessors are {n[0], x}
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            cand0[n] = {1'b0, pathMetric[2 * (n % 2)]}
                     + branchDist(symbol, expectedSymbol(stateT'(2 * (n % 2)), n >= 2));
            cand1[n] = {1'b0, pathMetric[2 * (n % 2) + 1]}
                     + branchDist(symbol, expectedSymbol(stateT'(2 * (n % 2) + 1), n >= 2));
            decisions[n] = cand1[n] < cand0[n];              // tie keeps the x = 0 branch
            chosen[n] = decisions[n] ? cand1[n] : cand0[n];
            nextMetric[n] = (chosen[n] > 5'd15) ? 4'hF : chosen[n][3:0];  // saturate
        end
    end

    // lowest metric wins, strict compare keeps the lower index on a tie
    always_comb begin
        minState = '0;
        for (int s = 1; s < 4; s++) begin
            if (pathMetric[s] < pathMetric[minState]) begin
                minState = stateT'(s);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < 4; s++) begin
                pathMetric[s] <= '0;
            end
        end else if (start) begin
            pathMetric[0] <= '0;  // encoder starts in state zero
            for (int s = 1; s < 4; s++) begin
                pathMetric[s] <= 4'hF;  // unreachable until two steps in
            end
        end else if (stepEn) begin
            for (int s = 0; s < 4; s++) begin
                pathMetric[s] <= nextMetric[s];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bestState  <= '0;
            bestMetric <= '0;
        end else if (finish) begin
            bestState  <= minState;
            bestMetric <= pathMetric[minState];
        end
    end

endmodule

//--- hw/viterbi/survivorMemory.sv
module survivorMemory #(
    parameter int MaxLen = ccPkg::MaxMsgLen
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wrEn,        // store decisions of the current step
    input  logic [2:0]        step,        // write index forward, read index in traceback
    input  logic [3:0]        decisions,
    input  logic              traceEn,     // one message bit per cycle
    input  logic              traceLoad,   // first traceback cycle
    input  ccPkg::stateT      bestState,
    input  logic [2:0]        length,
    output logic [MaxLen-1:0] message
);
    import ccPkg::*;

    logic [3:0]        decMem [MaxLen];  // one decision vector per step
    logic [3:0]        stepDec;
    stateT             traceState;       // state after the step being read
    stateT             curState;
    stateT             predState;
    logic [2:0]        bitIdx;
    logic [MaxLen-1:0] nextMsg;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            decMem[step] <= decisions;
        end
    end

    // traceback starts from the winning end state at step L-1
    assign curState  = traceLoad ? bestState : traceState;
    assign stepDec   = decMem[step];
    assign predState = {curState[0], stepDec[curState]};  // older bit shifts up
    assign bitIdx    = length - step - 3'd1;               // step t lands at bit L-1-t

    always_comb begin
        nextMsg = traceLoad ? '0 : message;  // clears bits above L-1 as well
        nextMsg[bitIdx] = curState[1];       // high bit is the input of this step
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            traceState <= '0;
            message    <= '0;
        end else if (traceEn) begin
            traceState <= predState;
            message    <= nextMsg;
        end
    end

endmodule

//--- hw/decodeCtrl.sv
module decodeCtrl #(
    parameter int MaxLen = ccPkg::MaxMsgLen
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              reqValid,
    input  ccPkg::decodeReqT  req,
    output logic              reqReady,
    input  logic              resultReady,
    output logic              resultValid,
    output ccPkg::decodeResT  result,
    output logic              start,
    output logic              stepEn,
    output logic              finish,
    output logic              traceLoad,
    output logic              traceEn,
    output logic              wrEn,
    output ccPkg::symbolT     symbol,
    output logic [2:0]        step,
    output logic [2:0]        length,
    input  logic [MaxLen-1:0] message,
    input  ccPkg::metricT     bestMetric
);
    import ccPkg::*;

    typedef enum logic [2:0] {Idle, Forward, Select, Trace, Hold} phaseT;

    phaseT              phase;
    logic [RxWidth-1:0] rxWord;     // latched received word
    logic [2:0]         len;        // message length of the current job
    logic [2:0]         stepCnt;    // up in forward, down in traceback
    logic [2:0]         symIdx;
    logic               lastStep;
    logic               accept;

    assign reqReady    = phase == Idle;
    assign resultValid = phase == Hold;  // result held until consumed
    assign accept      = reqValid && reqReady;

    assign start     = accept;           // metrics ready for the first forward cycle
    assign stepEn    = phase == Forward;
    assign wrEn      = phase == Forward;
    assign finish    = phase == Select;
    assign traceEn   = phase == Trace;
    assign lastStep  = stepCnt == len - 3'd1;
    assign traceLoad = traceEn && lastStep;

    // symbol t sits at bits 2(L-t)-1 .. 2(L-t)-2
    assign symIdx = len - stepCnt - 3'd1;
    assign symbol = rxWord[{symIdx, 1'b0} +: 2];
    assign step   = stepCnt;
    assign length = len;
    assign result = '{message: message, metric: bestMetric};

    always_ff @(posedge clk) begin
        if (accept) begin
            rxWord <= req.rxWord;
        end
    end

    // L forward, one select, L traceback, then hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= Idle;
            len     <= 3'd3;
            stepCnt <= '0;
        end else begin
            case (phase)
                Idle: begin
                    if (accept) begin
                        len     <= msgLength(req.lenCode);
                        stepCnt <= '0;
                        phase   <= Forward;
                    end
                end
                Forward: begin
                    if (lastStep) begin
                        phase <= Select;  // count stays at L-1 for traceback
                    end else begin
                        stepCnt <= stepCnt + 3'd1;
                    end
                end
                Select: phase <= Trace;
                Trace: begin
                    if (stepCnt == 3'd0) begin
                        phase <= Hold;
                    end else begin
                        stepCnt <= stepCnt - 3'd1;
                    end
                end
                Hold: begin
                    if (resultReady) begin
                        phase <= Idle;
                    end
                end
                default: phase <= Idle;
            endcase
        end
    end

endmodule

//--- hw/convDecoder.sv
module convDecoder #(
    parameter int MaxLen = ccPkg::MaxMsgLen
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqValid,
    input  ccPkg::decodeReqT req,
    output logic             reqReady,
    output logic             resultValid,
    output ccPkg::decodeResT result,
    input  logic             resultReady
);
    import ccPkg::*;

    logic              start;
    logic              stepEn;
    logic              finish;
    logic              traceLoad;
    logic              traceEn;
    logic              wrEn;
    symbolT            symbol;
    logic [2:0]        step;
    logic [2:0]        length;
    logic [3:0]        decisions;  // per-step survivor choices
    stateT             bestState;
    metricT            bestMetric;
    logic [MaxLen-1:0] message;

    decodeCtrl #(.MaxLen(MaxLen)) uCtrl (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .req(req), .reqReady(reqReady),
        .resultReady(resultReady), .resultValid(resultValid), .result(result),
        .start(start), .stepEn(stepEn), .finish(finish),
        .traceLoad(traceLoad), .traceEn(traceEn), .wrEn(wrEn),
        .symbol(symbol), .step(step), .length(length),
        .message(message), .bestMetric(bestMetric)
    );

    acsUnit uAcs (
        .clk(clk), .rst(rst),
        .start(start), .stepEn(stepEn), .finish(finish), .symbol(symbol),
        .decisions(decisions), .bestState(bestState), .bestMetric(bestMetric)
    );

    survivorMemory #(.MaxLen(MaxLen)) uSurv (
        .clk(clk), .rst(rst),
        .wrEn(wrEn), .step(step), .decisions(decisions),
        .traceEn(traceEn), .traceLoad(traceLoad), .bestState(bestState),
        .length(length), .message(message)
    );

endmodule

//--- dv/convDecoder_properties.sv
module convDecoder_properties (
    input logic             clk,
    input logic             rst,
    input logic             reqReady,
    input logic             resultValid,
    input ccPkg::decodeResT result,
    input logic             resultReady
);
    import ccPkg::*;

    // idle and holding a result are separate phases
    property readyNotWithValid;
        @(posedge clk) disable iff (rst) !(reqReady && resultValid);
    endproperty

    // a waiting result may not move until it is taken
    property resultHeld;
        @(posedge clk) disable iff (rst)
            resultValid && !resultReady |=> resultValid && $stable(result);
    endproperty

    property validLowAfterReset;
        @(posedge clk) rst |=> !resultValid;
    endproperty

    assert property (readyNotWithValid) else $error("reqReady and resultValid both high");
    assert property (resultHeld) else $error("result dropped or changed under back-pressure");
    assert property (validLowAfterReset) else $error("resultValid high right after reset");

endmodule

//--- dv/tbConvDecoder.sv
module tbConvDecoder;
    import ccPkg::*;

    localparam int NumClean   = 100;
    localparam int NumNoisy   = 100;
    localparam int MaxStall   = 8;
    localparam int CycleLimit = (NumClean + NumNoisy) * (15 + MaxStall + 4) + 16 + 32;

    logic      clk;
    logic      rst;
    logic      reqValid;
    decodeReqT req;
    logic      reqReady;
    logic      resultValid;
    decodeResT result;
    logic      resultReady;

    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testCount  = 0;
    int stallJobs  = 0;      // jobs that saw at least one stalled cycle
    int lenSeen [2][4];      // [clean/noisy][length code]

    convDecoder #(.MaxLen(MaxMsgLen)) u_dut (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .req(req), .reqReady(reqReady),
        .resultValid(resultValid), .result(result), .resultReady(resultReady)
    );

    bind convDecoder convDecoder_properties uProps (
        .clk(clk), .rst(rst), .reqReady(reqReady), .resultValid(resultValid),
        .result(result), .resultReady(resultReady)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // period 40
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout, the run went past %0d cycles", CycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int lengthOf(lenCodeT code);
        case (code)
            2'd0:    return 3;
            2'd1:    return 4;
            2'd2:    return 5;
            default: return 7;
        endcase
    endfunction

    function automatic logic [13:0] usedMask(int len);
        return 14'((1 << (2 * len)) - 1);  // low 2L received bits
    endfunction

    // shift-register encoder, symbol t at bits 2(L-t)-1 and 2(L-t)-2
    function automatic logic [13:0] encodeMsg(logic [6:0] msg, int len);
        logic [13:0] word;
        logic        newest;
        logic        older;
        logic        b;
        word   = '0;
        newest = 1'b0;
        older  = 1'b0;
        for (int t = 0; t < len; t++) begin
            b = msg[len - 1 - t];                    // first bit is the top one
            word[2 * (len - t) - 1] = b ^ newest ^ older;  // generator 7
            word[2 * (len - t) - 2] = b ^ older;           // generator 5
            older  = newest;
            newest = b;
        end
        return word;
    endfunction

    function automatic int distance(logic [13:0] a, logic [13:0] b, int len);
        logic [13:0] diff;
        int          d;
        diff = a ^ b;
        d    = 0;
        for (int i = 0; i < 2 * len; i++) begin
            d += int'(diff[i]);  // bits above 2L ignored
        end
        return d;
    endfunction

    // exhaustive search over all 2^L messages
    function automatic int bruteMin(logic [13:0] rx, int len);
        int best;
        int d;
        best = 2 * len + 1;
        for (int m = 0; m < (1 << len); m++) begin
            d = distance(encodeMsg(7'(m), len), rx, len);
            if (d < best) begin
                best = d;
            end
        end
        return best;
    endfunction

    task automatic checkValue(string name, int expected, int actual);
        checkCount++;
        assert (expected == actual) else begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkTrue(logic cond, string what);
        checkCount++;
        assert (cond) else begin
            $display("%s", what);
            errorCount++;
        end
    endtask

    task automatic reportTest(string name, int jobs, int errs);
        testCount++;
        $display("test %-12s %4d jobs, %0d errors", name, jobs, errs);
    endtask

    // one job: accept, wait for the result, stall, consume
    task automatic runJob(input logic [13:0] rx, input lenCodeT code, input int stall,
                          output logic [6:0] msg, output int metric);
        decodeResT held;
        int        latency;
        int        len;
        len = lengthOf(code);
        checkTrue(reqReady === 1'b1, "DUT was not ready for a new request");
        req      = '{rxWord: rx, lenCode: code};
        reqValid = 1'b1;
        @(posedge clk);  // accepting edge
        #5;
        req     = decodeReqT'($urandom);  // junk stays offered, must be ignored
        latency = 0;
        while (!resultValid) begin
            checkTrue(!reqReady, "reqReady went high while a job was in flight");
            @(posedge clk);
            #5;
            latency++;
        end
        checkValue("latency", 2 * len + 1, latency);
        held = result;
        if (stall > 0) begin
            stallJobs++;
        end
        repeat (stall) begin
            @(posedge clk);
            #5;
            checkTrue(resultValid && !reqReady, "handshake changed during back-pressure");
            checkTrue(result == held, "result changed while waiting for resultReady");
        end
        resultReady = 1'b1;
        reqValid    = 1'b0;
        @(posedge clk);  // result consumed here
        #5;
        resultReady = 1'b0;
        checkTrue(reqReady && !resultValid, "DUT did not go idle after the result was taken");
        msg    = held.message;
        metric = int'(held.metric);
    endtask

    task automatic resetTest();
        int startErrors;
        startErrors = errorCount;
        checkTrue(reqReady === 1'b1, "reqReady was not high after reset");
        checkTrue(resultValid === 1'b0, "resultValid was not low after reset");
        reportTest("reset", 0, errorCount - startErrors);
    endtask

    task automatic cleanDecodeTest();
        logic [6:0]  msg;
        logic [6:0]  got;
        logic [13:0] rx;
        lenCodeT     code;
        int          len;
        int          metric;
        int          startErrors;
        startErrors = errorCount;
        for (int j = 0; j < NumClean; j++) begin
            code = lenCodeT'($urandom_range(3));
            len  = lengthOf(code);
            msg  = 7'($urandom) & 7'((1 << len) - 1);
            rx   = encodeMsg(msg, len) | (14'($urandom) & ~usedMask(len));  // junk on top
            lenSeen[0][code]++;
            runJob(rx, code, $urandom_range(MaxStall), got, metric);
            checkValue("clean message", int'(msg), int'(got));
            checkValue("clean high bits", 0, int'(got >> len));
            checkValue("clean metric", 0, metric);
        end
        reportTest("cleanDecode", NumClean, errorCount - startErrors);
    endtask

    task automatic noisyDecodeTest();
        logic [6:0]  msg;
        logic [6:0]  got;
        logic [13:0] rx;
        logic [13:0] noise;
        lenCodeT     code;
        int          len;
        int          flips;
        int          metric;
        int          expMin;
        int          startErrors;
        startErrors = errorCount;
        for (int j = 0; j < NumNoisy; j++) begin
            code  = lenCodeT'($urandom_range(3));
            len   = lengthOf(code);
            msg   = 7'($urandom) & 7'((1 << len) - 1);
            flips = 1 + $urandom_range(2);
            noise = '0;
            while ($countones(noise) < flips) begin
                noise[$urandom_range(2 * len - 1)] = 1'b1;  // distinct positions only
            end
            rx = (encodeMsg(msg, len) ^ noise) | (14'($urandom) & ~usedMask(len));
            lenSeen[1][code]++;
            runJob(rx, code, $urandom_range(MaxStall), got, metric);
            expMin = bruteMin(rx, len);
            checkValue("noisy distance", expMin, distance(encodeMsg(got, len), rx, len));
            checkValue("noisy metric", expMin, metric);
            checkValue("noisy high bits", 0, int'(got >> len));
        end
        reportTest("noisyDecode", NumNoisy, errorCount - startErrors);
    endtask

    task automatic coverageTest();
        int startErrors;
        startErrors = errorCount;
        for (int k = 0; k < 2; k++) begin
            for (int c = 0; c < 4; c++) begin
                checkTrue(lenSeen[k][c] > 0, $sformatf("length code %0d was never used", c));
            end
        end
        checkTrue(stallJobs > 0, "no job ever saw back-pressure");
        reportTest("coverage", 0, errorCount - startErrors);
    endtask

    initial begin
        void'($urandom(32'h62fc));
        rst         = 1'b1;
        reqValid    = 1'b0;
        req         = '0;
        resultReady = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        @(posedge clk);
        #5;
        resetTest();
        cleanDecodeTest();
        noisyDecodeTest();
        coverageTest();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/ccPkg.sv
hw/viterbi/acsUnit.sv
hw/viterbi/survivorMemory.sv
hw/decodeCtrl.sv
hw/convDecoder.sv
dv/convDecoder_properties.sv
dv/tbConvDecoder.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the convDecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbConvDecoder -f vlog.f -o simConvDecoder
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simConvDecoder > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
